//--- design/display_options.sv
// Display options
// HDMI aspect ratio from resolution and menu, screen layer enables toggled
// by F1 to F6, and the delayed video mode change flag
`default_nettype none

module display_options #(
	parameter int MODE_DELAY = 5000000
) (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  saturn_cfg_pkg::video_menu_t     video_menu,
	input  wire [1:0]                       resolution,
	input  saturn_cfg_pkg::key_event_t      key_event,
	input  wire                             dl_busy,
	output saturn_cfg_pkg::aspect_t         aspect,
	output saturn_cfg_pkg::layer_en_t       layer_en,
	output logic                            new_vmode
);
	import saturn_cfg_pkg::*;

	localparam int CNT_W = $clog2(MODE_DELAY + 1);

	logic             toggle_q;
	logic             key_new;
	logic             pal_q;
	logic [CNT_W-1:0] mode_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Aspect ratio
	always_comb begin
		if (video_menu.force_wide) begin
			aspect = '{arx: 8'd16, ary: 8'd9};
		end else begin
			case (resolution)
				2'b00: aspect = '{arx: 8'd64, ary: 8'd49};
				2'b01: begin
					// 320 x 224
					if (video_menu.corrected) aspect = '{arx: 8'd10, ary: 8'd7};
					else aspect = '{arx: 8'd64, ary: 8'd49};
				end
				2'b10: aspect = '{arx: 8'd128, ary: 8'd105};
				default: begin
					// 320 x 240
					if (video_menu.corrected) aspect = '{arx: 8'd4, ary: 8'd3};
					else aspect = '{arx: 8'd128, ary: 8'd105};
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Layer enables

	// A fresh event flips the toggle bit
	assign key_new = (key_event.toggle != toggle_q) && key_event.pressed;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_q <= key_event.toggle;
			layer_en <= '1;
		end else begin
			toggle_q <= key_event.toggle;
			if (key_new) begin
				for (int i = 0; i < 6; i++) begin
					if (key_event.code == LAYER_KEY_CODES[i]) begin
						layer_en[i] <= ~layer_en[i];
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Video mode change timer
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal_q     <= video_menu.pal;
			mode_cnt  <= CNT_W'(MODE_DELAY);
			new_vmode <= 1'b0;
		end else if (dl_busy) begin
			pal_q    <= video_menu.pal;
			mode_cnt <= CNT_W'(MODE_DELAY);
		end else begin
			pal_q <= video_menu.pal;
			if (video_menu.pal != pal_q) begin
				mode_cnt <= CNT_W'(MODE_DELAY);
			end else if (mode_cnt != '0) begin
				mode_cnt <= mode_cnt - 1'b1;
				if (mode_cnt == CNT_W'(1)) begin
					new_vmode <= ~new_vmode;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/load_sequencer.sv
// Download sequencer
// Holds the VDPs in reset at session start, then turns each download word
// into a bus command for the current section of the image
`default_nettype none

module load_sequencer (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             dl_active,
	input  saturn_vdp_pkg::vdp_chip_e       dl_target,
	input  wire                             dl_req,
	input  saturn_cfg_pkg::dl_word_t        dl_word,
	output logic                            dl_ack,
	output logic                            cmd_req,
	output saturn_vdp_pkg::vdp_cmd_t        cmd,
	input  wire                             cmd_ack,
	output logic                            vdp_rst_n
);
	import saturn_vdp_pkg::*;
	import saturn_cfg_pkg::*;

	localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES);

	load_phase_e       phase;
	logic [HOLD_W-1:0] hold_cnt;
	logic              word_phase;
	logic              take_word;
	logic              take_disp;
	logic              cmd_done;

	// Command for one image word in the given section
	function automatic vdp_cmd_t word_cmd(load_phase_e ph, dl_word_t w);
		vdp_cmd_t c;
		c.chip     = (ph == PH_VDP1_VRAM) ? CHIP_VDP1 : CHIP_VDP2;
		c.addr_hi  = {13'd0, w.addr[17:15]};
		c.addr_lo  = {w.addr[14:0], 1'b0};
		// Image is little endian
		c.data     = {w.data[7:0], w.data[15:8]};
		c.wait_rdy = 1'b1;
		case (ph)
			PH_REG: begin
				c.addr_hi  = REG_ADDR_HI;
				c.wait_rdy = 1'b0;
			end
			PH_PAL: begin
				c.addr_hi  = PAL_ADDR_HI;
				c.addr_lo  = {w.addr[14:0] - PAL_BASE, 1'b0};
				c.wait_rdy = 1'b0;
			end
			default: ;
		endcase
		return c;
	endfunction

	assign word_phase = (phase == PH_VDP1_VRAM) || (phase == PH_VRAM) ||
		(phase == PH_REG) || (phase == PH_PAL);

	// Both handshakes must be back at rest before a new command
	assign take_word = word_phase && dl_req && !dl_ack && !cmd_req && !cmd_ack;
	assign take_disp = (phase == PH_DISP_ON) && !cmd_req && !cmd_ack;
	assign cmd_done  = cmd_req && cmd_ack;

	////////////////////////////////////////////////////////////////////////////
	// Phase FSM
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase     <= PH_IDLE;
			hold_cnt  <= '0;
			vdp_rst_n <= 1'b1;
			cmd_req   <= 1'b0;
			dl_ack    <= 1'b0;
		end else begin
			// Download side returns to rest once the source drops req
			if (dl_ack && !dl_req) begin
				dl_ack <= 1'b0;
			end
			if (take_word || take_disp) begin
				cmd_req <= 1'b1;
			end

			case (phase)
				PH_IDLE: begin
					hold_cnt <= '0;
					if (dl_active) begin
						vdp_rst_n <= 1'b0;
						phase     <= PH_RESET;
					end
				end

				PH_RESET: begin
					hold_cnt <= hold_cnt + 1'b1;
					if (hold_cnt == HOLD_W'(RESET_HOLD_CYCLES - 1)) begin
						vdp_rst_n <= 1'b1;
						phase     <= (dl_target == CHIP_VDP1) ? PH_VDP1_VRAM : PH_VRAM;
					end
				end

				PH_VDP1_VRAM, PH_VRAM, PH_REG, PH_PAL: begin
					if (cmd_done) begin
						cmd_req <= 1'b0;
						dl_ack  <= 1'b1;
						// Address is still valid until the source sees ack
						case (phase)
							PH_VDP1_VRAM:
								if (dl_word.addr == VRAM_LAST_ADDR) phase <= PH_END;
							PH_VRAM:
								if (dl_word.addr == VRAM_LAST_ADDR) phase <= PH_REG;
							PH_REG:
								if (dl_word.addr == REG_LAST_ADDR) phase <= PH_PAL;
							default:
								if (dl_word.addr == PAL_LAST_ADDR) phase <= PH_DISP_ON;
						endcase
					end
				end

				PH_DISP_ON: begin
					if (cmd_done) begin
						cmd_req <= 1'b0;
						phase   <= PH_END;
					end
				end

				default: begin
					if (!dl_active) begin
						phase <= PH_IDLE;
					end
				end
			endcase
		end
	end

	// Command payload
	always_ff @(posedge clk_sys) begin
		if (take_word) begin
			cmd <= word_cmd(phase, dl_word);
		end else if (take_disp) begin
			cmd.chip     <= CHIP_VDP2;
			cmd.addr_hi  <= REG_ADDR_HI;
			cmd.addr_lo  <= 16'h0000;
			cmd.data     <= DISP_ON_DATA;
			cmd.wait_rdy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	a_cmd_stable: assert property (@(posedge clk_sys) disable iff (reset)
		cmd_req && $past(cmd_req) |-> $stable(cmd))
		else $error("cmd changed during a command request");

endmodule

`default_nettype wire

//--- design/saturn_cfg_pkg.sv
// Loader and display option definitions
// Download word layout, loader phases and phase limits, header words for
// register and palette writes, menu bits and PS/2 key events
`default_nettype none

package saturn_cfg_pkg;

	// Word address inside the downloaded state image
	typedef logic [18:0] dl_addr_t;

	typedef struct packed {
		dl_addr_t    addr;
		logic [15:0] data;
	} dl_word_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_RESET,
		PH_VDP1_VRAM,
		PH_VRAM,
		PH_REG,
		PH_PAL,
		PH_DISP_ON,
		PH_END
	} load_phase_e;

	// Last word address of each image section
	localparam dl_addr_t VRAM_LAST_ADDR = 19'h3FFFF;
	localparam dl_addr_t REG_LAST_ADDR  = 19'h400FF;
	localparam dl_addr_t PAL_LAST_ADDR  = 19'h408FF;

	// VDP2 register block and color RAM
	localparam logic [15:0] REG_ADDR_HI  = 16'h0018;
	localparam logic [15:0] PAL_ADDR_HI  = 16'h0010;
	localparam logic [14:0] PAL_BASE     = 15'h0100;
	// TVMD with DISP set
	localparam logic [15:0] DISP_ON_DATA = 16'h8000;

	localparam int RESET_HOLD_CYCLES = 4;

	typedef struct packed {
		logic [7:0] arx;
		logic [7:0] ary;
	} aspect_t;

	typedef struct packed {
		logic force_wide;
		logic corrected;
		logic pal;
	} video_menu_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} key_event_t;

	typedef logic [5:0] layer_en_t;

	// Set 2 scan codes F1 to F6
	localparam logic [8:0] LAYER_KEY_CODES [0:5] = '{
		9'h005, 9'h006, 9'h004, 9'h00C, 9'h003, 9'h00B
	};

endpackage

`default_nettype wire

//--- design/saturn_vdp_pkg.sv
// VDP bus definitions
// Data word, chip select, the registered bus outputs toward both VDPs and
// the command that one three-beat bus cycle carries
`default_nettype none

package saturn_vdp_pkg;

	// One word on the shared VDP data bus
	typedef logic [15:0] vdp_data_t;

	// Target chip of a bus cycle
	typedef enum logic {
		CHIP_VDP1 = 1'b0,
		CHIP_VDP2 = 1'b1
	} vdp_chip_e;

	// Bus outputs, all strobes active low
	typedef struct packed {
		vdp_data_t data;
		logic      ad_n;
		logic      dten_n;
		logic      cs1_n;
		logic      cs2_n;
		logic      we_n;
	} vdp_bus_t;

	// Bus with both chips deselected and nothing driven
	localparam vdp_bus_t VDP_BUS_IDLE = '{
		data:   16'h0000,
		ad_n:   1'b1,
		dten_n: 1'b1,
		cs1_n:  1'b1,
		cs2_n:  1'b1,
		we_n:   1'b1
	};

	// One write cycle: address high, address low, data
	typedef struct packed {
		vdp_chip_e chip;
		vdp_data_t addr_hi;
		vdp_data_t addr_lo;
		vdp_data_t data;
		// Hold the release beat until the chip reports ready
		logic      wait_rdy;
	} vdp_cmd_t;

endpackage

`default_nettype wire

//--- design/vdp_bus_cycle.sv
// VDP bus cycle engine
// Plays one command as address high, address low and data beats on the
// shared VDP bus, paced by a half-rate clock enable
`default_nettype none

module vdp_bus_cycle (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             cmd_req,
	input  saturn_vdp_pkg::vdp_cmd_t        cmd,
	output logic                            cmd_ack,
	output saturn_vdp_pkg::vdp_bus_t        vdp_bus,
	input  wire                             rdy1_n,
	input  wire                             rdy2_n
);
	import saturn_vdp_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BEATS,
		ST_DONE,
		ST_ACK
	} cyc_state_e;

	cyc_state_e state;
	logic       ce;
	logic [1:0] beat;
	logic       rdy_n;
	logic       sel1_n;
	logic       sel2_n;

	assign rdy_n  = (cmd.chip == CHIP_VDP1) ? rdy1_n : rdy2_n;
	assign sel1_n = (cmd.chip != CHIP_VDP1);
	assign sel2_n = (cmd.chip != CHIP_VDP2);

	// VDPs sample the bus on every second clock
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce <= 1'b0;
		end else begin
			ce <= ~ce;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= ST_IDLE;
			beat    <= 2'd0;
			cmd_ack <= 1'b0;
			vdp_bus <= VDP_BUS_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					beat <= 2'd0;
					if (cmd_req && !cmd_ack) begin
						state <= ST_BEATS;
					end
				end

				ST_BEATS: if (ce) begin
					case (beat)
						2'd0: begin
							vdp_bus.data  <= cmd.addr_hi;
							vdp_bus.cs1_n <= sel1_n;
							vdp_bus.cs2_n <= sel2_n;
							vdp_bus.we_n  <= 1'b0;
							beat          <= 2'd1;
						end
						2'd1: begin
							vdp_bus.data <= cmd.addr_lo;
							beat         <= 2'd2;
						end
						2'd2: begin
							vdp_bus.data   <= cmd.data;
							vdp_bus.ad_n   <= 1'b0;
							vdp_bus.dten_n <= 1'b0;
							beat           <= 2'd3;
						end
						default: begin
							// VRAM writes stretch here until the chip catches up
							if (!cmd.wait_rdy || !rdy_n) begin
								vdp_bus <= VDP_BUS_IDLE;
								beat    <= 2'd0;
								state   <= ST_DONE;
							end
						end
					endcase
				end

				ST_DONE: begin
					cmd_ack <= 1'b1;
					state   <= ST_ACK;
				end

				default: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						state   <= ST_IDLE;
					end
				end
			endcase
		end
	end

	a_one_select: assert property (@(posedge clk_sys) disable iff (reset)
		vdp_bus.cs1_n || vdp_bus.cs2_n)
		else $error("both VDP selects low");

endmodule

`default_nettype wire

//--- design/vdp_load_top.sv
// VDP state loader top level
// Download words go through the sequencer into VDP bus cycles; display
// options run beside it and see the download as busy
`default_nettype none

module vdp_load_top #(
	parameter int MODE_DELAY = 5000000
) (
	input  wire                             clk_sys,
	input  wire                             reset,

	input  wire                             dl_active,
	input  saturn_vdp_pkg::vdp_chip_e       dl_target,
	input  wire                             dl_req,
	input  saturn_cfg_pkg::dl_word_t        dl_word,
	output logic                            dl_ack,

	output saturn_vdp_pkg::vdp_bus_t        vdp_bus,
	input  wire                             rdy1_n,
	input  wire                             rdy2_n,
	output logic                            vdp_rst_n,

	input  saturn_cfg_pkg::video_menu_t     video_menu,
	// Bit 1 is 240 lines, bit 0 is 320 wide
	input  wire [1:0]                       resolution,
	input  saturn_cfg_pkg::key_event_t      key_event,
	output saturn_cfg_pkg::aspect_t         aspect,
	output saturn_cfg_pkg::layer_en_t       layer_en,
	output logic                            new_vmode
);
	import saturn_vdp_pkg::*;

	logic     cmd_req;
	logic     cmd_ack;
	vdp_cmd_t cmd;

	load_sequencer u_seq (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_target (dl_target),
		.dl_req    (dl_req),
		.dl_word   (dl_word),
		.dl_ack    (dl_ack),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.vdp_rst_n (vdp_rst_n)
	);

	vdp_bus_cycle u_bus (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cmd_req (cmd_req),
		.cmd     (cmd),
		.cmd_ack (cmd_ack),
		.vdp_bus (vdp_bus),
		.rdy1_n  (rdy1_n),
		.rdy2_n  (rdy2_n)
	);

	display_options #(
		.MODE_DELAY (MODE_DELAY)
	) u_opts (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.video_menu (video_menu),
		.resolution (resolution),
		.key_event  (key_event),
		.dl_busy    (dl_active),
		.aspect     (aspect),
		.layer_en   (layer_en),
		.new_vmode  (new_vmode)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -f sim.log && rm -rf obj_dir \
	&& verilator --binary --timing --assert -Wno-fatal --top-module tb_vdp_load -f vlog.f \
	&& ./obj_dir/Vtb_vdp_load > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log || exit 1

//--- testbench/tb_vdp_load.sv
// Testbench for the VDP state loader
// Models both VDPs as bus slaves with random ready delays and runs directed
// tests for download sessions, aspect ratio, layer keys and mode change flag
`default_nettype none

module tb_vdp_load;
	import saturn_vdp_pkg::*;
	import saturn_cfg_pkg::*;

	localparam int MODE_DELAY     = 20;
	localparam int TIMEOUT_CYCLES = 20000;

	localparam vdp_bus_t BUS_RELEASED = '{
		data:   16'h0000,
		ad_n:   1'b1,
		dten_n: 1'b1,
		cs1_n:  1'b1,
		cs2_n:  1'b1,
		we_n:   1'b1
	};

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_active;
	vdp_chip_e   dl_target;
	logic        dl_req;
	dl_word_t    dl_word;
	logic        dl_ack;
	vdp_bus_t    vdp_bus;
	wire         rdy1_n;
	wire         rdy2_n;
	logic        vdp_rst_n;
	video_menu_t video_menu;
	logic [1:0]  resolution;
	key_event_t  key_event;
	aspect_t     aspect;
	layer_en_t   layer_en;
	logic        new_vmode;

	// Slave model state, index 0 is VDP1
	logic [1:0]  rdy_l;
	logic        in_cyc [2];
	logic        data_seen [2];
	int          rdy_wait [2];
	int          rdy_cnt [2];
	logic [31:0] rng [2];
	vdp_cmd_t    rx_cur [2];
	vdp_cmd_t    rx_q1 [$];
	vdp_cmd_t    rx_q2 [$];

	logic [31:0] rng_data;
	layer_en_t   exp_layers;
	int          errors = 0;
	int          cycle_cnt = 0;

	assign rdy1_n = rdy_l[0];
	assign rdy2_n = rdy_l[1];

	vdp_load_top #(
		.MODE_DELAY (MODE_DELAY)
	) i_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_target  (dl_target),
		.dl_req     (dl_req),
		.dl_word    (dl_word),
		.dl_ack     (dl_ack),
		.vdp_bus    (vdp_bus),
		.rdy1_n     (rdy1_n),
		.rdy2_n     (rdy2_n),
		.vdp_rst_n  (vdp_rst_n),
		.video_menu (video_menu),
		.resolution (resolution),
		.key_event  (key_event),
		.aspect     (aspect),
		.layer_en   (layer_en),
		.new_vmode  (new_vmode)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			fail_stop("Timeout, the tests did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// VDP slave models
	always begin : vdp_models
		logic cs_n;
		@(posedge clk_sys);
		#10;
		for (int c = 0; c < 2; c++) begin
			cs_n = (c == 0) ? vdp_bus.cs1_n : vdp_bus.cs2_n;
			if (!cs_n) begin
				if (!in_cyc[c]) begin
					in_cyc[c]          = 1'b1;
					rx_cur[c].chip     = (c == 0) ? CHIP_VDP1 : CHIP_VDP2;
					rx_cur[c].addr_hi  = vdp_bus.data;
					rx_cur[c].wait_rdy = 1'b0;
				end else if (vdp_bus.ad_n) begin
					// Last word before the data beat
					rx_cur[c].addr_lo = vdp_bus.data;
				end
				if (!vdp_bus.ad_n && !data_seen[c]) begin
					data_seen[c]   = 1'b1;
					rx_cur[c].data = vdp_bus.data;
					if (c == 0) begin
						rx_q1.push_back(rx_cur[c]);
					end else begin
						rx_q2.push_back(rx_cur[c]);
					end
					rng[c]      = lcg_next(rng[c]);
					rdy_wait[c] = int'(rng[c][31:16] % 16'd6);
				end
				if (data_seen[c] && rdy_l[c]) begin
					if (rdy_wait[c] == 0) begin
						rdy_l[c] = 1'b0;
						rdy_cnt[c]++;
					end else begin
						rdy_wait[c]--;
					end
				end
			end else begin
				in_cyc[c]    = 1'b0;
				data_seen[c] = 1'b0;
				rdy_l[c]     = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers and compare tasks
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic next_rand(output logic [15:0] r);
		rng_data = lcg_next(rng_data);
		r = rng_data[31:16];
	endtask

	task automatic tick;
		@(posedge clk_sys);
		#10;
	endtask

	task automatic fail_stop(input string msg);
		errors++;
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			fail_stop($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic check_bus(input string name, input vdp_bus_t exp, input vdp_bus_t act);
		if (exp !== act) begin
			fail_stop($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// The wait flag never reaches the bus, so only the visible fields count
	task automatic check_cmd(input string name, input vdp_cmd_t exp, input vdp_cmd_t act);
		if ({exp.chip, exp.addr_hi, exp.addr_lo, exp.data} !==
			{act.chip, act.addr_hi, act.addr_lo, act.data}) begin
			fail_stop($sformatf(
				"[FAIL] %s: expected chip %0d %h %h %h, actual chip %0d %h %h %h", name,
				exp.chip, exp.addr_hi, exp.addr_lo, exp.data,
				act.chip, act.addr_hi, act.addr_lo, act.data));
		end
	endtask

	task automatic check_aspect(input string name, input aspect_t exp, input aspect_t act);
		if (exp !== act) begin
			fail_stop($sformatf("[FAIL] %s: expected %0d:%0d, actual %0d:%0d",
				name, exp.arx, exp.ary, act.arx, act.ary));
		end
	endtask

	task automatic check_layers(input string name, input layer_en_t exp, input layer_en_t act);
		if (exp !== act) begin
			fail_stop($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	function automatic vdp_cmd_t build_cmd(input vdp_chip_e chip, input logic [15:0] hi,
		input logic [15:0] lo, input logic [15:0] data);
		vdp_cmd_t c;
		c.chip     = chip;
		c.addr_hi  = hi;
		c.addr_lo  = lo;
		c.data     = data;
		c.wait_rdy = 1'b0;
		return c;
	endfunction

	task automatic pop_check(input string name, input vdp_cmd_t exp);
		vdp_cmd_t act;
		if (exp.chip == CHIP_VDP1 && rx_q1.size() == 0) begin
			fail_stop($sformatf("%s: no bus cycle was seen on select 1", name));
		end else if (exp.chip == CHIP_VDP2 && rx_q2.size() == 0) begin
			fail_stop($sformatf("%s: no bus cycle was seen on select 2", name));
		end else begin
			act = (exp.chip == CHIP_VDP1) ? rx_q1.pop_front() : rx_q2.pop_front();
			check_cmd(name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Download source
	task automatic send_word(input dl_addr_t addr, input logic [15:0] data);
		dl_word.addr = addr;
		dl_word.data = data;
		dl_req       = 1'b1;
		while (!dl_ack) begin
			tick;
		end
		dl_req = 1'b0;
		while (dl_ack) begin
			tick;
		end
	endtask

	task automatic send_checked(input string name, input vdp_chip_e chip, input dl_addr_t addr,
		input logic [15:0] hi, input logic [15:0] lo);
		logic [15:0] data;
		next_rand(data);
		send_word(addr, data);
		// Little endian image words arrive byte swapped
		pop_check(name, build_cmd(chip, hi, lo, {data[7:0], data[15:8]}));
	endtask

	// Word address split into the high part and a byte address low part
	task automatic vram_word(input string name, input vdp_chip_e chip, input dl_addr_t addr);
		send_checked(name, chip, addr, 16'(addr[17:0] >> 15), 16'(addr[14:0] * 2));
	endtask

	task automatic start_session(input vdp_chip_e target);
		dl_target = target;
		dl_active = 1'b1;
		tick;
		for (int i = 0; i < RESET_HOLD_CYCLES; i++) begin
			check_bit("vdp reset hold", 1'b0, vdp_rst_n);
			tick;
		end
		check_bit("vdp reset release", 1'b1, vdp_rst_n);
	endtask

	task automatic end_session(input string name);
		dl_active = 1'b0;
		repeat (4) tick;
		check_bus({name, " bus idle"}, BUS_RELEASED, vdp_bus);
		check_bit({name, " ack low"}, 1'b0, dl_ack);
		check_bit({name, " no stray cycles"}, 1'b1, rx_q1.size() == 0 && rx_q2.size() == 0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	task automatic reset_state;
		check_bus("reset bus", BUS_RELEASED, vdp_bus);
		check_bit("reset dl_ack", 1'b0, dl_ack);
		check_bit("reset vdp_rst_n", 1'b1, vdp_rst_n);
		check_layers("reset layers", 6'b111111, layer_en);
	endtask

	task automatic vdp1_session;
		logic [15:0] r_lo;
		logic [15:0] r_hi;
		dl_addr_t    addr;
		int          base;
		start_session(CHIP_VDP1);
		base = rdy_cnt[0];
		for (int i = 0; i < 4; i++) begin
			next_rand(r_lo);
			next_rand(r_hi);
			addr = (i == 3) ? VRAM_LAST_ADDR : {1'b0, r_hi[1:0], r_lo[15:1], 1'b0};
			vram_word("vdp1 vram", CHIP_VDP1, addr);
			check_bit("vdp1 ready before ack", 1'b1, rdy_cnt[0] == base + i + 1);
		end
		end_session("vdp1");
	endtask

	task automatic vdp2_session;
		logic [15:0] r_lo;
		logic [15:0] r_hi;
		logic [15:0] k;
		dl_addr_t    addr;
		int          base;
		start_session(CHIP_VDP2);
		base = rdy_cnt[1];
		for (int i = 0; i < 3; i++) begin
			next_rand(r_lo);
			next_rand(r_hi);
			addr = (i == 2) ? VRAM_LAST_ADDR : {1'b0, r_hi[1:0], r_lo[15:1], 1'b0};
			vram_word("vdp2 vram", CHIP_VDP2, addr);
			check_bit("vdp2 ready before ack", 1'b1, rdy_cnt[1] == base + i + 1);
		end
		for (int i = 0; i < 3; i++) begin
			next_rand(r_lo);
			k = (i == 2) ? 16'h00FF : {9'd0, r_lo[6:0]};
			send_checked("vdp2 register", CHIP_VDP2, 19'h40000 + 19'(k), 16'h0018, 16'(k * 2));
		end
		// Palette entries counted from the start of color RAM
		for (int i = 0; i < 3; i++) begin
			next_rand(r_lo);
			k = (i == 2) ? 16'h07FF : {6'd0, r_lo[9:0]};
			send_checked("vdp2 palette", CHIP_VDP2, 19'h40100 + 19'(k), 16'h0010, 16'(k * 2));
		end
		while (rx_q2.size() == 0) begin
			tick;
		end
		pop_check("vdp2 display on", build_cmd(CHIP_VDP2, 16'h0018, 16'h0000, 16'h8000));
		end_session("vdp2");
	endtask

	function automatic aspect_t expected_aspect(input logic fw, input logic corr,
		input logic [1:0] res);
		aspect_t a;
		if (fw) begin
			a = '{arx: 8'd16, ary: 8'd9};
		end else if (res[0] && corr) begin
			if (res[1]) a = '{arx: 8'd4, ary: 8'd3};
			else a = '{arx: 8'd10, ary: 8'd7};
		end else begin
			if (res[1]) a = '{arx: 8'd128, ary: 8'd105};
			else a = '{arx: 8'd64, ary: 8'd49};
		end
		return a;
	endfunction

	task automatic aspect_table;
		for (int fw = 0; fw < 2; fw++) begin
			for (int corr = 0; corr < 2; corr++) begin
				for (int res = 0; res < 4; res++) begin
					video_menu.force_wide = fw[0];
					video_menu.corrected  = corr[0];
					resolution            = res[1:0];
					tick;
					check_aspect($sformatf("aspect fw%0d corr%0d res%0d", fw, corr, res),
						expected_aspect(fw[0], corr[0], res[1:0]), aspect);
				end
			end
		end
	endtask

	task automatic send_key(input string name, input logic [8:0] code, input logic pressed,
		input logic flip, input int layer);
		key_event.code    = code;
		key_event.pressed = pressed;
		if (flip) begin
			key_event.toggle = ~key_event.toggle;
		end
		if (layer >= 0) begin
			exp_layers[layer] = ~exp_layers[layer];
		end
		tick;
		check_layers(name, exp_layers, layer_en);
	endtask

	task automatic layer_toggles;
		exp_layers = 6'b111111;
		for (int k = 0; k < 6; k++) begin
			send_key($sformatf("F%0d key", k + 1), LAYER_KEY_CODES[k], 1'b1, 1'b1, k);
		end
		send_key("unused key", 9'h01C, 1'b1, 1'b1, -1);
		send_key("F3 again", LAYER_KEY_CODES[2], 1'b1, 1'b1, 2);
		// Same event left on the port is no new press
		send_key("F3 held", LAYER_KEY_CODES[2], 1'b1, 1'b0, -1);
		repeat (3) tick;
		check_layers("F3 held", exp_layers, layer_en);
		send_key("F1 release", LAYER_KEY_CODES[0], 1'b0, 1'b1, -1);
	endtask

	task automatic pal_flip_check(input string name);
		logic v0;
		int   n;
		v0 = new_vmode;
		video_menu.pal = ~video_menu.pal;
		for (n = 0; n < MODE_DELAY - 2; n++) begin
			tick;
			check_bit({name, " hold"}, v0, new_vmode);
		end
		while (new_vmode == v0 && n < MODE_DELAY + 2) begin
			tick;
			n++;
		end
		check_bit({name, " change"}, ~v0, new_vmode);
	endtask

	task automatic mode_flag;
		logic v;
		// Let the count started at the end of the download run out
		repeat (MODE_DELAY + 10) tick;
		pal_flip_check("pal on");
		v = new_vmode;
		for (int i = 0; i < 2 * MODE_DELAY; i++) begin
			tick;
			check_bit("mode steady", v, new_vmode);
		end
		pal_flip_check("pal off");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		reset      = 1'b1;
		dl_active  = 1'b0;
		dl_target  = CHIP_VDP1;
		dl_req     = 1'b0;
		dl_word    = '0;
		video_menu = '0;
		resolution = 2'b00;
		key_event  = '0;
		rdy_l      = 2'b11;
		rng_data   = 32'd61;
		for (int c = 0; c < 2; c++) begin
			in_cyc[c]    = 1'b0;
			data_seen[c] = 1'b0;
			rdy_wait[c]  = 0;
			rdy_cnt[c]   = 0;
			rng[c]       = 32'd61;
		end
		repeat (4) @(posedge clk_sys);
		#10;
		reset = 1'b0;
		tick;

		reset_state;
		vdp1_session;
		vdp2_session;
		aspect_table;
		layer_toggles;
		mode_flag;

		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
design/saturn_vdp_pkg.sv
design/saturn_cfg_pkg.sv
design/display_options.sv
design/vdp_bus_cycle.sv
design/load_sequencer.sv
design/vdp_load_top.sv
testbench/tb_vdp_load.sv
